// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := lsi_core_tb
FILELIST  := lsi_core.f
OBJ_DIR   := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: lsi_core.f
+incdir+source
source/lsi_pkg.sv
source/lsi_ctrl_if.sv
source/lsi_alu.sv
source/lsi_datapath.sv
source/lsi_bus_watchdog.sv
source/lsi_sequencer.sv
source/lsi_core.sv
verif/lsi_core_tb.sv

// File: source/lsi_alu.sv
`timescale 1ns/1ns
`default_nettype none
`include "lsi_defines.svh"

module lsi_alu (
	input  logic [`LSI_WORD-1:0] a,          // source operand
	input  logic [`LSI_WORD-1:0] b,          // destination operand
	input  logic [3:0]           op,
	input  logic                 c_in,       // current C, passed on where kept
	output logic [`LSI_WORD-1:0] result,
	output logic [3:0]           flags,      // n z v c
	output logic [3:0]           flag_mask   // which flags the op updates
);

	localparam int W = `LSI_WORD;

	logic [W:0] add_ab;
	logic [W:0] sub_ab;   // a - b, top bit is borrow
	logic [W:0] sub_ba;   // b - a
	logic       v;
	logic       c;

	assign add_ab = {1'b0, a} + {1'b0, b};
	assign sub_ab = {1'b0, a} - {1'b0, b};
	assign sub_ba = {1'b0, b} - {1'b0, a};

	always_comb begin
		result    = b;
		v         = 1'b0;
		c         = c_in;
		flag_mask = 4'b1110;   // logic ops keep C
		case (op)
			`LSI_ALU_MOV: result = a;
			`LSI_ALU_BIT: result = a & b;
			`LSI_ALU_BIC: result = ~a & b;
			`LSI_ALU_BIS: result = a | b;
			`LSI_ALU_CMP: begin
				result    = sub_ab[W-1:0];
				v         = (a[W-1] != b[W-1]) && (result[W-1] != a[W-1]);
				c         = sub_ab[W];
				flag_mask = 4'b1111;
			end
			`LSI_ALU_ADD: begin
				result    = add_ab[W-1:0];
				v         = (a[W-1] == b[W-1]) && (result[W-1] != a[W-1]);
				c         = add_ab[W];
				flag_mask = 4'b1111;
			end
			`LSI_ALU_SUB: begin
				// dst minus src
				result    = sub_ba[W-1:0];
				v         = (a[W-1] != b[W-1]) && (result[W-1] != b[W-1]);
				c         = sub_ba[W];
				flag_mask = 4'b1111;
			end
			`LSI_ALU_CLR: begin
				result    = '0;
				c         = 1'b0;
				flag_mask = 4'b1111;
			end
			`LSI_ALU_COM: begin
				result    = ~b;
				c         = 1'b1;
				flag_mask = 4'b1111;
			end
			`LSI_ALU_INC: begin
				result = b + 1'b1;
				v      = (b == {1'b0, {(W-1){1'b1}}});   // 077777 wraps
			end
			`LSI_ALU_DEC: begin
				result = b - 1'b1;
				v      = (b == {1'b1, {(W-1){1'b0}}});   // 100000 wraps
			end
			`LSI_ALU_NEG: begin
				result    = '0 - b;
				v         = (result == {1'b1, {(W-1){1'b0}}});
				c         = |result;
				flag_mask = 4'b1111;
			end
			`LSI_ALU_TST: begin
				c         = 1'b0;
				flag_mask = 4'b1111;
			end
			default: ;
		endcase
	end

	// n and z always follow the result
	assign flags = {result[W-1], ~|result, v, c};

endmodule

`default_nettype wire

// File: source/lsi_bus_watchdog.sv
`timescale 1ns/1ns
`default_nettype none
`include "lsi_defines.svh"

module lsi_bus_watchdog (
	input  logic clk,
	input  logic reset_n,
	input  logic wait_active,   // access phase with pready low
	output logic expired
);

	localparam int CW = $clog2(`LSI_WDT_LIMIT + 1);

	logic [CW-1:0] count;

	// saturates at the limit, cleared between waits
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n)
			count <= '0;
		else if (!wait_active)
			count <= '0;
		else if (!expired)
			count <= count + 1'b1;
	end

	assign expired = (count == CW'(`LSI_WDT_LIMIT));

endmodule

`default_nettype wire

// File: source/lsi_core.sv
`timescale 1ns/1ns
`default_nettype none
`include "lsi_defines.svh"

module lsi_core (
	input  logic                 clk,
	input  logic                 reset_n,
	// APB master
	output logic [`LSI_WORD-1:0] paddr,
	output logic                 psel,
	output logic                 penable,
	output logic                 pwrite,
	output logic [`LSI_WORD-1:0] pwdata,
	input  logic [`LSI_WORD-1:0] prdata,
	input  logic                 pready,
	input  logic                 pslverr,
	// status
	output logic                 halted,
	output logic                 bus_error,
	output logic [3:0]           psw        // n z v c
);

	logic wait_active;
	logic expired;

	lsi_ctrl_if ctrl ();

	lsi_sequencer i_sequencer (
		.clk          (clk),
		.reset_n      (reset_n),
		.ctrl         (ctrl),
		.prdata_valid (pready),
		.pslverr      (pslverr),
		.expired      (expired),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.wait_active  (wait_active),
		.halted       (halted),
		.bus_error    (bus_error)
	);

	lsi_datapath i_datapath (
		.clk     (clk),
		.reset_n (reset_n),
		.ctrl    (ctrl),
		.prdata  (prdata),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.psw     (psw)
	);

	lsi_bus_watchdog i_watchdog (
		.clk         (clk),
		.reset_n     (reset_n),
		.wait_active (wait_active),
		.expired     (expired)
	);

endmodule

`default_nettype wire

// File: source/lsi_ctrl_if.sv
`timescale 1ns/1ns
`default_nettype none

interface lsi_ctrl_if import lsi_pkg::*; ();

	// sequencer to datapath
	logic       ir_load;
	logic       pc_inc;
	logic       src_load;
	logic       src_from_bus;    // immediate operand instead of a register
	logic       dst_load;
	logic       reg_write;
	logic       psw_load;
	logic       branch_take_en;
	logic       addr_sel;        // 0 PC, 1 destination register
	logic [3:0] alu_op;

	// datapath back to sequencer
	lsi_instr_u ir;
	logic       taken;

	modport seq (
		output ir_load, pc_inc, src_load, src_from_bus, dst_load,
		output reg_write, psw_load, branch_take_en, addr_sel, alu_op,
		input  ir, taken
	);

	modport dp (
		input  ir_load, pc_inc, src_load, src_from_bus, dst_load,
		input  reg_write, psw_load, branch_take_en, addr_sel, alu_op,
		output ir, taken
	);

endinterface

`default_nettype wire

// File: source/lsi_datapath.sv
`timescale 1ns/1ns
`default_nettype none
`include "lsi_defines.svh"

module lsi_datapath import lsi_pkg::*; (
	input  logic                 clk,
	input  logic                 reset_n,
	lsi_ctrl_if.dp               ctrl,
	input  logic [`LSI_WORD-1:0] prdata,
	output logic [`LSI_WORD-1:0] paddr,
	output logic [`LSI_WORD-1:0] pwdata,
	output logic [3:0]           psw
);

	localparam int W = `LSI_WORD;

	logic [W-1:0] regs [0:7];   // R7 is the PC
	lsi_instr_u   ir_q;
	logic [W-1:0] src_q;
	logic [W-1:0] dst_q;
	logic [3:0]   nzvc;

	logic [W-1:0] pc;
	logic [W-1:0] branch_ofs;
	logic [W-1:0] alu_result;
	logic [3:0]   alu_flags;
	logic [3:0]   alu_mask;
	logic         no_writeback;

	assign pc = regs[7];

	// offset is in words, shift left once and sign extend
	assign branch_ofs = {{(W-9){ir_q.br.offset[7]}}, ir_q.br.offset, 1'b0};

	// compare-type ops only touch the flags
	assign no_writeback = (ctrl.alu_op == `LSI_ALU_CMP) || (ctrl.alu_op == `LSI_ALU_BIT) ||
		(ctrl.alu_op == `LSI_ALU_TST);

	// ==========================================================================
	// branch condition
	// ==========================================================================
	always_comb begin
		case (ir_q.br.code)
			7'd1:    ctrl.taken = 1'b1;                   // BR
			7'd2:    ctrl.taken = ~nzvc[2];               // BNE
			7'd3:    ctrl.taken = nzvc[2];                // BEQ
			7'd4:    ctrl.taken = ~(nzvc[3] ^ nzvc[1]);   // BGE
			7'd5:    ctrl.taken = nzvc[3] ^ nzvc[1];      // BLT
			default: ctrl.taken = 1'b0;
		endcase
	end

	// ==========================================================================
	// registers, IR, PSW
	// ==========================================================================
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			for (int i = 0; i < 7; i++)
				regs[i] <= '0;
			regs[7] <= `LSI_RESET_PC;
			ir_q    <= '0;
			nzvc    <= '0;
		end else begin
			if (ctrl.ir_load)
				ir_q <= prdata;
			if (ctrl.reg_write && !no_writeback)
				regs[ir_q.op.dst_reg] <= alu_result;
			if (ctrl.pc_inc)
				regs[7] <= pc + W'(2);
			else if (ctrl.branch_take_en && ctrl.taken)
				regs[7] <= pc + branch_ofs;
			// masked flags keep their old value
			if (ctrl.psw_load)
				nzvc <= (alu_flags & alu_mask) | (nzvc & ~alu_mask);
		end
	end

	// operand latches
	always_ff @(posedge clk) begin
		if (ctrl.src_load)
			src_q <= ctrl.src_from_bus ? prdata : regs[ir_q.op.src_reg];
		if (ctrl.dst_load)
			dst_q <= regs[ir_q.op.dst_reg];
	end

	lsi_alu i_alu (
		.a         (src_q),
		.b         (dst_q),
		.op        (ctrl.alu_op),
		.c_in      (nzvc[0]),
		.result    (alu_result),
		.flags     (alu_flags),
		.flag_mask (alu_mask)
	);

	// bus side
	assign paddr  = ctrl.addr_sel ? regs[ir_q.op.dst_reg] : pc;   // mode 1 store address
	assign pwdata = alu_result;
	assign psw    = nzvc;
	assign ctrl.ir = ir_q;

endmodule

`default_nettype wire

// File: source/lsi_defines.svh
`ifndef LSI_DEFINES_SVH
`define LSI_DEFINES_SVH

// datapath width and start address
`define LSI_WORD      16
`define LSI_RESET_PC  16'h0000

// access-phase cycles without pready before the access is abandoned
`define LSI_WDT_LIMIT 16

// ALU operation codes, sequencer to ALU
`define LSI_ALU_MOV   4'd0
`define LSI_ALU_CMP   4'd1
`define LSI_ALU_BIT   4'd2
`define LSI_ALU_BIC   4'd3
`define LSI_ALU_BIS   4'd4
`define LSI_ALU_ADD   4'd5
`define LSI_ALU_SUB   4'd6
`define LSI_ALU_CLR   4'd7
`define LSI_ALU_COM   4'd8
`define LSI_ALU_INC   4'd9
`define LSI_ALU_DEC   4'd10
`define LSI_ALU_NEG   4'd11
`define LSI_ALU_TST   4'd12

`endif

// File: source/lsi_pkg.sv
`default_nettype none

package lsi_pkg;

	// ==========================================================================
	// instruction word
	// ==========================================================================
	// one 16-bit word, read two ways
	//
	// operand view, double operand:  B OOO SSS sss DDD ddd
	//   MOV 01, CMP 02, BIT 03, BIC 04, BIS 05, ADD 06, SUB 16 (octal)
	//
	// single operand reuses the upper bits and the destination:
	//   0 000 101 xxx DDD ddd   with xxx picking CLR COM INC DEC NEG - - TST
	//
	// branch view:                   B CCCCCCC oooooooo
	//   BR 1, BNE 2, BEQ 3, BGE 4, BLT 5 in the code field
	//   offset counts words, target is PC + 2 * offset
	//
	// HALT is the all-zero word

	typedef union packed {
		struct packed {
			logic       byte_op;   // bit 15, set only by SUB here
			logic [2:0] opcode;    // bits 14:12
			logic [2:0] src_mode;  // bits 11:9
			logic [2:0] src_reg;   // bits 8:6
			logic [2:0] dst_mode;  // bits 5:3
			logic [2:0] dst_reg;   // bits 2:0
		} op;
		struct packed {
			logic              byte_op;
			logic [6:0]        code;    // bits 14:8
			logic signed [7:0] offset;  // signed word offset
		} br;
	} lsi_instr_u;

endpackage

`default_nettype wire

// File: source/lsi_sequencer.sv
`timescale 1ns/1ns
`default_nettype none
`include "lsi_defines.svh"

module lsi_sequencer (
	input  logic   clk,
	input  logic   reset_n,
	lsi_ctrl_if.seq ctrl,
	input  logic   prdata_valid,   // pready
	input  logic   pslverr,
	input  logic   expired,
	output logic   psel,
	output logic   penable,
	output logic   pwrite,
	output logic   wait_active,
	output logic   halted,
	output logic   bus_error
);

	localparam logic [3:0] ST_FETCH_S = 4'd0;
	localparam logic [3:0] ST_FETCH_A = 4'd1;
	localparam logic [3:0] ST_DECODE  = 4'd2;
	localparam logic [3:0] ST_OP_S    = 4'd3;
	localparam logic [3:0] ST_OP_A    = 4'd4;
	localparam logic [3:0] ST_EXEC    = 4'd5;
	localparam logic [3:0] ST_WR_S    = 4'd6;
	localparam logic [3:0] ST_WR_A    = 4'd7;
	localparam logic [3:0] ST_HALT    = 4'd8;

	logic [3:0] state, state_nx;
	logic [6:0] br_code;
	logic [3:0] op_sel;
	logic       is_dop, is_sop, is_br;
	logic       src_ok, dst_ok, legal;
	logic       need_imm, need_write, no_result;
	logic       access, done, bus_fail, go_halt;

	// ==========================================================================
	// decode, operand view of IR
	// ==========================================================================
	assign br_code = {ctrl.ir.op.opcode, ctrl.ir.op.src_mode, ctrl.ir.op.src_reg[2]};

	always_comb begin
		is_dop = 1'b0;
		is_sop = 1'b0;
		is_br  = 1'b0;
		op_sel = `LSI_ALU_MOV;
		if (ctrl.ir.op.byte_op) begin
			if (ctrl.ir.op.opcode == 3'd6) begin   // SUB, the only 1xxxxx kept
				is_dop = 1'b1;
				op_sel = `LSI_ALU_SUB;
			end
		end else if (ctrl.ir.op.opcode != 3'd0) begin
			is_dop = 1'b1;
			case (ctrl.ir.op.opcode)
				3'd1:    op_sel = `LSI_ALU_MOV;
				3'd2:    op_sel = `LSI_ALU_CMP;
				3'd3:    op_sel = `LSI_ALU_BIT;
				3'd4:    op_sel = `LSI_ALU_BIC;
				3'd5:    op_sel = `LSI_ALU_BIS;
				3'd6:    op_sel = `LSI_ALU_ADD;
				default: is_dop = 1'b0;
			endcase
		end else if (ctrl.ir.op.src_mode == 3'd5) begin
			is_sop = 1'b1;
			case (ctrl.ir.op.src_reg)
				3'd0:    op_sel = `LSI_ALU_CLR;
				3'd1:    op_sel = `LSI_ALU_COM;
				3'd2:    op_sel = `LSI_ALU_INC;
				3'd3:    op_sel = `LSI_ALU_DEC;
				3'd4:    op_sel = `LSI_ALU_NEG;
				3'd7:    op_sel = `LSI_ALU_TST;
				default: is_sop = 1'b0;   // ADC SBC not here
			endcase
		end else if (br_code inside {[7'd1:7'd5]}) begin
			is_br = 1'b1;
		end
	end

	assign src_ok     = (ctrl.ir.op.src_mode == 3'd0) ||
		(ctrl.ir.op.src_mode == 3'd2 && ctrl.ir.op.src_reg == 3'd7);
	assign dst_ok     = (ctrl.ir.op.dst_mode[2:1] == 2'b00);
	assign legal      = (is_dop && src_ok && dst_ok) || (is_sop && dst_ok) || is_br;
	assign need_imm   = is_dop && (ctrl.ir.op.src_mode == 3'd2);
	assign no_result  = (op_sel == `LSI_ALU_CMP) || (op_sel == `LSI_ALU_BIT) ||
		(op_sel == `LSI_ALU_TST);
	assign need_write = (ctrl.ir.op.dst_mode == 3'd1) && !no_result;

	// ==========================================================================
	// APB master
	// ==========================================================================
	assign access      = (state == ST_FETCH_A) || (state == ST_OP_A) || (state == ST_WR_A);
	assign psel        = access || (state == ST_FETCH_S) || (state == ST_OP_S) ||
		(state == ST_WR_S);
	assign penable     = access;
	assign pwrite      = (state == ST_WR_S) || (state == ST_WR_A);
	assign wait_active = access && !prdata_valid;
	assign bus_fail    = access && (expired || (prdata_valid && pslverr));   // timeout wins
	assign done        = access && prdata_valid && !bus_fail;

	always_comb begin
		state_nx            = state;
		ctrl.ir_load        = 1'b0;
		ctrl.pc_inc         = 1'b0;
		ctrl.src_load       = 1'b0;
		ctrl.src_from_bus   = 1'b0;
		ctrl.dst_load       = 1'b0;
		ctrl.reg_write      = 1'b0;
		ctrl.psw_load       = 1'b0;
		ctrl.branch_take_en = 1'b0;
		case (state)
			ST_FETCH_S: state_nx = ST_FETCH_A;
			ST_FETCH_A: if (done) begin
				ctrl.ir_load = 1'b1;
				ctrl.pc_inc  = 1'b1;
				state_nx     = ST_DECODE;
			end
			ST_DECODE: begin
				if (!legal)
					state_nx = ST_HALT;   // HALT and anything unsupported
				else if (is_br)
					state_nx = ctrl.taken ? ST_EXEC : ST_FETCH_S;   // skip exec if not taken
				else begin
					ctrl.src_load = !need_imm;
					ctrl.dst_load = 1'b1;
					state_nx      = need_imm ? ST_OP_S : ST_EXEC;
				end
			end
			ST_OP_S: state_nx = ST_OP_A;
			ST_OP_A: if (done) begin
				ctrl.src_load     = 1'b1;
				ctrl.src_from_bus = 1'b1;
				ctrl.pc_inc       = 1'b1;   // step over the immediate word
				state_nx          = ST_EXEC;
			end
			ST_EXEC: begin
				if (is_br) begin
					ctrl.branch_take_en = 1'b1;
					state_nx            = ST_FETCH_S;
				end else begin
					ctrl.psw_load  = 1'b1;
					ctrl.reg_write = (ctrl.ir.op.dst_mode == 3'd0);
					state_nx       = need_write ? ST_WR_S : ST_FETCH_S;
				end
			end
			ST_WR_S: state_nx = ST_WR_A;
			ST_WR_A: if (done)
				state_nx = ST_FETCH_S;
			ST_HALT: if (!halted)
				state_nx = ST_FETCH_S;   // out of reset the core idles here one cycle
			default: state_nx = ST_HALT;
		endcase
		if (bus_fail)
			state_nx = ST_HALT;
	end

	assign ctrl.alu_op   = op_sel;
	assign ctrl.addr_sel = pwrite;
	assign go_halt       = (state_nx == ST_HALT) && (state != ST_HALT);

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state     <= ST_HALT;
			halted    <= 1'b0;
			bus_error <= 1'b0;
		end else begin
			state <= state_nx;
			if (go_halt)
				halted <= 1'b1;      // sticky until reset
			if (bus_fail)
				bus_error <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: verif/lsi_core_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "lsi_defines.svh"

module lsi_core_tb import lsi_pkg::*; ();

	localparam int OP_MOV = 0;
	localparam int OP_CMP = 1;
	localparam int OP_BIT = 2;
	localparam int OP_BIC = 3;
	localparam int OP_BIS = 4;
	localparam int OP_ADD = 5;
	localparam int OP_SUB = 6;
	localparam int OP_CLR = 7;
	localparam int OP_COM = 8;
	localparam int OP_INC = 9;
	localparam int OP_DEC = 10;
	localparam int OP_NEG = 11;
	localparam int OP_TST = 12;
	localparam int OP_BR  = 13;
	localparam int OP_BNE = 14;
	localparam int OP_BEQ = 15;
	localparam int OP_BGE = 16;
	localparam int OP_BLT = 17;
	localparam int NO_FAULT = 0;
	localparam int STALL    = 1;
	localparam int SLVERR   = 2;
	localparam logic [15:0] STORE_R1 = 16'o010112;   // MOV R1,(R2)

	logic                 clk = 1'b0;
	logic                 reset_n;
	logic [`LSI_WORD-1:0] paddr;
	logic                 psel;
	logic                 penable;
	logic                 pwrite;
	logic [`LSI_WORD-1:0] pwdata;
	logic [`LSI_WORD-1:0] prdata;
	logic                 pready;
	logic                 pslverr;
	logic                 halted;
	logic                 bus_error;
	logic [3:0]           psw;

	logic [15:0] mem [0:255];   // word memory behind the APB slave
	logic        waits_en;
	int          fault_mode;
	int          wait_left;
	int          wr_count;
	logic [15:0] wr_addr;
	logic [15:0] wr_data;
	int          cycles;
	int          limit;

	// stimulus table with one program per row
	int          q_op    [$];
	logic [15:0] q_a     [$];
	logic [15:0] q_b     [$];
	logic [15:0] q_addr  [$];
	logic        q_waits [$];
	int          q_fault [$];
	logic [15:0] q_word  [$];   // expected stored word
	logic [3:0]  q_psw   [$];   // expected nzvc after the op at address 12

	lsi_core i_dut (
		.clk       (clk),
		.reset_n   (reset_n),
		.paddr     (paddr),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.halted    (halted),
		.bus_error (bus_error),
		.psw       (psw)
	);

	initial begin
		forever #20 clk = ~clk;
	end

	// ========================================================================
	// APB slave on the falling edge
	// ========================================================================
	always @(negedge clk) begin
		pready  = 1'b0;
		pslverr = 1'b0;
		if (psel && !penable)
			wait_left = waits_en ? int'($urandom % 4) : 0;   // 0 to 3 wait cycles
		else if (psel && penable) begin
			if (pwrite && fault_mode == STALL)
				pready = 1'b0;   // never answer the store
			else if (wait_left > 0)
				wait_left--;
			else begin
				pready = 1'b1;
				if (pwrite && fault_mode == SLVERR)
					pslverr = 1'b1;
				else if (pwrite) begin
					mem[paddr[8:1]] = pwdata;
					wr_count++;
					wr_addr = paddr;
					wr_data = pwdata;
				end else
					prdata = mem[paddr[8:1]];
			end
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("run timed out after %0d cycles", cycles);
			abort_run();
		end
	end

	// ========================================================================
	// checks
	// ========================================================================
	task automatic abort_run();
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_word(input logic [`LSI_WORD-1:0] got,
		input logic [`LSI_WORD-1:0] exp, input string what);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_psw(input logic [3:0] got, input logic [3:0] exp, input string what);
		if (got !== exp) begin
			$display("Error at %0t ns: %s nzvc is %b, expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	// ========================================================================
	// program building
	// ========================================================================
	// op R0,R1 or op R1 with branches hopping one word forward
	function automatic lsi_instr_u encode(input int op);
		lsi_instr_u ins;
		ins = '0;
		if (op >= OP_BR) begin
			ins.br.code   = 7'(op - OP_BR + 1);   // BR 1 up to BLT 5
			ins.br.offset = 8'sd1;
		end else begin
			ins.op.dst_reg = 3'd1;
			case (op)
				OP_MOV: ins.op.opcode = 3'd1;
				OP_CMP: ins.op.opcode = 3'd2;
				OP_BIT: ins.op.opcode = 3'd3;
				OP_BIC: ins.op.opcode = 3'd4;
				OP_BIS: ins.op.opcode = 3'd5;
				OP_ADD: ins.op.opcode = 3'd6;
				OP_SUB: ins.op.opcode = 3'd6;
				OP_COM: ins.op.src_reg = 3'd1;
				OP_INC: ins.op.src_reg = 3'd2;
				OP_DEC: ins.op.src_reg = 3'd3;
				OP_NEG: ins.op.src_reg = 3'd4;
				OP_TST: ins.op.src_reg = 3'd7;
				default: ;   // CLR keeps 0
			endcase
			ins.op.byte_op = (op == OP_SUB);
			if (op >= OP_CLR)
				ins.op.src_mode = 3'd5;   // single operand group
		end
		return ins;
	endfunction

	task automatic add_row(input int op, input logic [15:0] a, input logic [15:0] b,
		input logic waits, input int fault, input logic [15:0] word, input logic [3:0] nzvc);
		q_addr.push_back(16'h0100 + 16'(2 * q_op.size()));
		q_op.push_back(op);
		q_a.push_back(a);
		q_b.push_back(b);
		q_waits.push_back(waits);
		q_fault.push_back(fault);
		q_word.push_back(word);
		q_psw.push_back(nzvc);
	endtask

	// expected values from the PDP-11 word rules with C still 0 from reset
	task automatic build_table();
		add_row(OP_MOV, 16'h1234, 16'h0000, 1'b0, NO_FAULT, 16'h1234, 4'b0000);
		add_row(OP_ADD, 16'h7fff, 16'h0001, 1'b0, NO_FAULT, 16'h8000, 4'b1010);
		add_row(OP_ADD, 16'hffff, 16'h0001, 1'b1, NO_FAULT, 16'h0000, 4'b0101);
		add_row(OP_ADD, 16'hffff, 16'h0001, 1'b0, NO_FAULT, 16'h0000, 4'b0101);
		add_row(OP_SUB, 16'h0003, 16'h0001, 1'b1, NO_FAULT, 16'hfffe, 4'b1001);
		add_row(OP_SUB, 16'h0001, 16'h8000, 1'b0, NO_FAULT, 16'h7fff, 4'b0010);
		add_row(OP_CMP, 16'h0005, 16'h0005, 1'b0, NO_FAULT, 16'h0005, 4'b0100);
		add_row(OP_CMP, 16'h8000, 16'h0001, 1'b1, NO_FAULT, 16'h0001, 4'b0010);
		add_row(OP_CMP, 16'h0001, 16'h0002, 1'b0, NO_FAULT, 16'h0002, 4'b1001);
		add_row(OP_BIT, 16'h00f0, 16'h0f0f, 1'b1, NO_FAULT, 16'h0f0f, 4'b0100);
		add_row(OP_BIC, 16'h00ff, 16'h1234, 1'b0, NO_FAULT, 16'h1200, 4'b0000);
		add_row(OP_BIS, 16'h0f00, 16'h80f0, 1'b1, NO_FAULT, 16'h8ff0, 4'b1000);
		add_row(OP_CLR, 16'h5555, 16'h1234, 1'b0, NO_FAULT, 16'h0000, 4'b0100);
		add_row(OP_COM, 16'h5555, 16'h00ff, 1'b1, NO_FAULT, 16'hff00, 4'b1001);
		add_row(OP_INC, 16'h5555, 16'h7fff, 1'b0, NO_FAULT, 16'h8000, 4'b1010);
		add_row(OP_DEC, 16'h5555, 16'h8000, 1'b1, NO_FAULT, 16'h7fff, 4'b0010);
		add_row(OP_NEG, 16'h5555, 16'h0001, 1'b0, NO_FAULT, 16'hffff, 4'b1001);
		add_row(OP_NEG, 16'h5555, 16'h0000, 1'b1, NO_FAULT, 16'h0000, 4'b0100);
		add_row(OP_TST, 16'h5555, 16'h8000, 1'b0, NO_FAULT, 16'h8000, 4'b1000);
		// branches follow CMP R0,R1 and a skipped INC leaves R1 as b
		add_row(OP_BR,  16'h0001, 16'h0002, 1'b1, NO_FAULT, 16'h0002, 4'b1001);
		add_row(OP_BNE, 16'h0003, 16'h0003, 1'b0, NO_FAULT, 16'h0004, 4'b0100);
		add_row(OP_BEQ, 16'h0003, 16'h0003, 1'b1, NO_FAULT, 16'h0003, 4'b0100);
		add_row(OP_BGE, 16'h8000, 16'h0001, 1'b0, NO_FAULT, 16'h0002, 4'b0010);
		add_row(OP_BLT, 16'h8000, 16'h0001, 1'b1, NO_FAULT, 16'h0001, 4'b0010);
		add_row(OP_BNE, 16'h0007, 16'h0003, 1'b1, NO_FAULT, 16'h0003, 4'b0000);
		add_row(OP_MOV, 16'habcd, 16'h0000, 1'b0, STALL,    16'habcd, 4'b1000);
		add_row(OP_ADD, 16'h0001, 16'h0001, 1'b1, SLVERR,   16'h0002, 4'b0000);
	endtask

	task automatic load_program(input int i);
		for (int k = 0; k < 256; k++)
			mem[k] = ~{k[7:0], k[7:0]};
		mem[0] = 16'o012700;   // MOV #a,R0
		mem[1] = q_a[i];
		mem[2] = 16'o012701;   // MOV #b,R1
		mem[3] = q_b[i];
		mem[4] = 16'o012702;   // MOV #addr,R2
		mem[5] = q_addr[i];
		if (q_op[i] >= OP_BR) begin
			mem[6]  = encode(OP_CMP);
			mem[7]  = encode(q_op[i]);
			mem[8]  = encode(OP_INC);
			mem[9]  = STORE_R1;
			mem[10] = 16'h0000;
		end else begin
			mem[6] = encode(q_op[i]);
			mem[7] = STORE_R1;
			mem[8] = 16'h0000;   // HALT
		end
	endtask

	// ========================================================================
	// one program from reset to halt
	// ========================================================================
	task automatic run_row(input int i);
		logic psw_seen;
		logic first_seen;
		@(negedge clk);
		reset_n = 1'b0;
		load_program(i);
		waits_en   = q_waits[i];
		fault_mode = q_fault[i];
		wr_count   = 0;
		psw_seen   = 1'b0;
		first_seen = 1'b0;
		repeat (5) @(negedge clk);
		check_bit(psel, 1'b0, $sformatf("row %0d psel in reset", i));
		check_bit(penable, 1'b0, $sformatf("row %0d penable in reset", i));
		check_bit(halted, 1'b0, $sformatf("row %0d halted in reset", i));
		check_bit(bus_error, 1'b0, $sformatf("row %0d bus_error in reset", i));
		reset_n = 1'b1;
		while (!halted) begin
			@(negedge clk);
			if (!first_seen) begin
				first_seen = 1'b1;   // first cycle after reset release
				check_bit(psel, 1'b1, $sformatf("row %0d first setup psel", i));
				check_word(paddr, `LSI_RESET_PC, $sformatf("row %0d first fetch address", i));
				check_bit(penable, 1'b0, $sformatf("row %0d first setup penable", i));
				check_bit(pwrite, 1'b0, $sformatf("row %0d first setup pwrite", i));
			end
			if (psel && !penable && !pwrite && paddr == 16'h000e) begin
				psw_seen = 1'b1;   // fetch right after the op at 12
				check_psw(psw, q_psw[i], $sformatf("row %0d psw", i));
			end
		end
		repeat (3) @(negedge clk);
		check_bit(halted, 1'b1, $sformatf("row %0d halted held", i));
		check_bit(psel, 1'b0, $sformatf("row %0d psel after halt", i));
		check_bit(psw_seen, 1'b1, $sformatf("row %0d fetch at 000e seen", i));
		if (q_fault[i] == NO_FAULT) begin
			check_bit(bus_error, 1'b0, $sformatf("row %0d bus_error", i));
			check_word(16'(wr_count), 16'd1, $sformatf("row %0d completed writes", i));
			check_word(wr_addr, q_addr[i], $sformatf("row %0d write address", i));
			check_word(wr_data, q_word[i], $sformatf("row %0d write data", i));
		end else begin
			check_bit(bus_error, 1'b1, $sformatf("row %0d bus_error", i));
			check_word(16'(wr_count), 16'd0, $sformatf("row %0d completed writes", i));
		end
	endtask

	initial begin
		void'($urandom(44));
		reset_n    = 1'b0;
		prdata     = '0;
		pready     = 1'b0;
		pslverr    = 1'b0;
		waits_en   = 1'b0;
		fault_mode = NO_FAULT;
		wait_left  = 0;
		wr_count   = 0;
		cycles     = 0;
		limit      = 0;
		build_table();
		// per row 8 instructions of 3 slow accesses plus watchdog and reset times two
		limit = q_op.size() * (8 * (3 * (2 + 3) + 1) + `LSI_WDT_LIMIT + 5) * 2;
		for (int i = 0; i < q_op.size(); i++)
			run_row(i);
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire
